// File: hw/dbgmon_pkg.sv
package dbgmon_pkg;

    localparam int TRACE_DEPTH = 128;
    localparam int TRACE_AW    = 7;
    localparam int REC_W       = 256;
    localparam int NUM_BP      = 4;
    localparam int NUM_WP      = 4;

    localparam int REG_BASE = 12;  // paddr bit, 1 selects registers

    // 64-bit registers take two words, low word first
    localparam logic [12:0] REG_PC         = 13'h1000;
    localparam logic [12:0] REG_BP0        = 13'h1100;
    localparam logic [12:0] REG_BP1        = 13'h1108;
    localparam logic [12:0] REG_BP2        = 13'h1110;
    localparam logic [12:0] REG_BP3        = 13'h1118;
    localparam logic [12:0] REG_WP0        = 13'h1120;
    localparam logic [12:0] REG_WP1        = 13'h1128;
    localparam logic [12:0] REG_WP2        = 13'h1130;
    localparam logic [12:0] REG_WP3        = 13'h1138;
    localparam logic [12:0] REG_VC_EXC     = 13'h1140;
    localparam logic [12:0] REG_VC_IRQ     = 13'h1144;
    localparam logic [12:0] REG_DELAY      = 13'h1148;
    localparam logic [12:0] REG_STOP_TRACE = 13'h114C;
    localparam logic [12:0] REG_IE         = 13'h1150;

    localparam logic [NUM_BP-1:0][12:0] REG_BP = {REG_BP3, REG_BP2, REG_BP1, REG_BP0};
    localparam logic [NUM_WP-1:0][12:0] REG_WP = {REG_WP3, REG_WP2, REG_WP1, REG_WP0};

    typedef enum logic [1:0] {
        KIND_LOAD  = 2'd0,
        KIND_STORE = 2'd1,
        KIND_EXEC  = 2'd2,   // no memory access
        KIND_TRAP  = 2'd3
    } rec_kind_t;

    typedef union packed {
        struct packed {
            rec_kind_t   kind;
            logic [30:0] rsvd_hi;
            logic [62:0] pc;       // pc[63:1]
            logic [32:0] rsvd_lo;
            logic [62:0] addr;     // addr[63:1]
            logic [63:0] data;
        } exec;
        struct packed {
            rec_kind_t    kind;
            logic [157:0] rsvd_hi;
            logic         is_interrupt;
            logic [25:0]  rsvd_lo;
            logic [4:0]   cause;
            logic [63:0]  data;
        } trap;
    } dbgmon_rec_u;

endpackage

// File: hw/trace_sram.sv
module trace_sram (
    input  logic                            clk,
    input  logic                            we,
    input  logic [dbgmon_pkg::TRACE_AW-1:0] addr,
    input  logic [63:0]                     din,
    output logic [63:0]                     dout
);
    import dbgmon_pkg::*;

    logic [63:0] mem [TRACE_DEPTH];

    always_ff @(posedge clk) begin
        if (we)
            mem[addr] <= din;
        dout <= mem[addr];  // old data on a write cycle
    end

endmodule

// File: hw/dbgmon_regs.sv
module dbgmon_regs (
    input  logic                                clk,
    input  logic                                rstn,
    input  logic                                psel,
    input  logic                                penable,
    input  logic                                pwrite,
    input  logic [12:0]                         paddr,
    input  logic [31:0]                         pwdata,
    input  logic [63:0]                         pc,
    input  logic                                stop,
    output logic [dbgmon_pkg::NUM_BP-1:0][62:0] bp_addr,
    output logic [dbgmon_pkg::NUM_BP-1:0]       bp_en,
    output logic [dbgmon_pkg::NUM_WP-1:0][62:0] wp_addr,
    output logic [dbgmon_pkg::NUM_WP-1:0]       wp_en,
    output logic [31:0]                         vc_exc,
    output logic [31:0]                         vc_irq,
    output logic [15:0]                         delay,
    output logic                                delay_wr,
    output logic                                stop_trace,
    output logic                                ie,
    output logic [31:0]                         reg_rdata
);
    import dbgmon_pkg::*;

    logic        wr_en;
    logic        stop_wr;
    logic [31:0] rd_mux;

    assign wr_en   = psel && pwrite && !penable;  // setup phase
    assign stop_wr = wr_en && (paddr == REG_STOP_TRACE);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            bp_addr <= '0;
            bp_en   <= '0;
            wp_addr <= '0;
            wp_en   <= '0;
        end else if (wr_en) begin
            for (int i = 0; i < NUM_BP; i++) begin
                if (paddr == REG_BP[i])
                    bp_addr[i][31:0] <= pwdata;
                else if (paddr == REG_BP[i] + 13'h4)
                    {bp_en[i], bp_addr[i][62:32]} <= pwdata;  // enable in bit 31
            end
            for (int i = 0; i < NUM_WP; i++) begin
                if (paddr == REG_WP[i])
                    wp_addr[i][31:0] <= pwdata;
                else if (paddr == REG_WP[i] + 13'h4)
                    {wp_en[i], wp_addr[i][62:32]} <= pwdata;
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            vc_exc <= '0;
            vc_irq <= '0;
            delay  <= '0;
            ie     <= 1'b0;
        end else if (wr_en) begin
            case (paddr)
                REG_VC_EXC: vc_exc <= pwdata;
                REG_VC_IRQ: vc_irq <= pwdata;
                REG_DELAY:  delay  <= pwdata[15:0];
                REG_IE:     ie     <= pwdata[0];
                default: ;
            endcase
        end
    end

    // reload pulse lands once delay holds the new value
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn)
            delay_wr <= 1'b0;
        else
            delay_wr <= wr_en && (paddr == REG_DELAY);
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn)
            stop_trace <= 1'b0;
        else if (stop)
            stop_trace <= 1'b1;  // trigger beats software
        else if (stop_wr)
            stop_trace <= pwdata[0];
    end

    always_comb begin
        case (paddr)
            REG_PC:         rd_mux = pc[31:0];
            REG_PC + 13'h4: rd_mux = pc[63:32];
            REG_VC_EXC:     rd_mux = vc_exc;
            REG_VC_IRQ:     rd_mux = vc_irq;
            REG_DELAY:      rd_mux = {16'd0, delay};
            REG_STOP_TRACE: rd_mux = {31'd0, stop_trace};
            REG_IE:         rd_mux = {31'd0, ie};
            default:        rd_mux = '0;
        endcase
        for (int i = 0; i < NUM_BP; i++) begin
            if (paddr == REG_BP[i])
                rd_mux = bp_addr[i][31:0];
            if (paddr == REG_BP[i] + 13'h4)
                rd_mux = {bp_en[i], bp_addr[i][62:32]};
        end
        for (int i = 0; i < NUM_WP; i++) begin
            if (paddr == REG_WP[i])
                rd_mux = wp_addr[i][31:0];
            if (paddr == REG_WP[i] + 13'h4)
                rd_mux = {wp_en[i], wp_addr[i][62:32]};
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn)
            reg_rdata <= '0;
        else
            reg_rdata <= rd_mux;  // valid in access phase
    end

    a_stop_wins: assert property (@(posedge clk) disable iff (!rstn)
        stop && stop_wr |=> stop_trace);

endmodule

// File: hw/dbgmon_trigger.sv
module dbgmon_trigger (
    input  logic                                clk,
    input  logic                                rstn,
    input  logic                                rec_valid,
    input  dbgmon_pkg::dbgmon_rec_u             rec,
    input  logic [dbgmon_pkg::NUM_BP-1:0][62:0] bp_addr,
    input  logic [dbgmon_pkg::NUM_BP-1:0]       bp_en,
    input  logic [dbgmon_pkg::NUM_WP-1:0][62:0] wp_addr,
    input  logic [dbgmon_pkg::NUM_WP-1:0]       wp_en,
    input  logic [31:0]                         vc_exc,
    input  logic [31:0]                         vc_irq,
    input  logic [15:0]                         delay,
    input  logic                                delay_wr,
    input  logic                                stop_trace,
    output logic                                stop
);
    import dbgmon_pkg::*;

    rec_kind_t         kind;
    logic [NUM_BP-1:0] bp_hit;
    logic [NUM_WP-1:0] wp_hit;
    logic              vc_bit;
    logic              vc_hit;
    logic              hit;
    logic              hit_latch;
    logic [15:0]       cnt;

    assign kind = rec.exec.kind;

    always_comb begin
        for (int i = 0; i < NUM_BP; i++) begin
            bp_hit[i] = bp_en[i] && (kind != KIND_TRAP)
                        && (bp_addr[i] == rec.exec.pc);
        end
        for (int i = 0; i < NUM_WP; i++) begin
            wp_hit[i] = wp_en[i] && (kind == KIND_LOAD || kind == KIND_STORE)
                        && (wp_addr[i] == rec.exec.addr);
        end
    end

    assign vc_bit = rec.trap.is_interrupt ? vc_irq[rec.trap.cause] : vc_exc[rec.trap.cause];
    assign vc_hit = (kind == KIND_TRAP) && vc_bit;

    // no new triggers while the buffer is frozen
    assign hit = rec_valid && !stop_trace && (|bp_hit || |wp_hit || vc_hit);

    // delay 0 and 1 stop on the hit itself
    assign stop = !stop_trace && ((hit && !hit_latch && cnt <= 16'd1)
                                  || (hit_latch && cnt == 16'd0));

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            cnt       <= '0;
            hit_latch <= 1'b0;
        end else begin
            if (delay_wr || stop || stop_trace)
                cnt <= delay;
            else if ((hit || hit_latch) && cnt != 16'd0)
                cnt <= cnt - {15'd0, rec_valid};  // hit record counts too
            hit_latch <= (hit || hit_latch) && !stop && !stop_trace;
        end
    end

    a_stop_cause: assert property (@(posedge clk) disable iff (!rstn)
        stop |-> hit || hit_latch);

    a_stop_frozen: assert property (@(posedge clk) disable iff (!rstn)
        stop_trace |-> !stop);

endmodule

// File: hw/dbgmon_trace.sv
module dbgmon_trace (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    rec_valid,
    input  dbgmon_pkg::dbgmon_rec_u rec,
    input  logic                    stop_trace,
    input  logic [12:0]             paddr,
    output logic [31:0]             trace_rdata
);
    import dbgmon_pkg::*;

    logic [TRACE_AW-1:0] wr_ptr;
    logic [TRACE_AW-1:0] sram_addr;
    logic                sram_we;
    logic [REC_W-1:0]    rd_rec;

    assign sram_we = rec_valid && !stop_trace;

    // frozen: entry 0 is the oldest slot, which is wr_ptr itself
    assign sram_addr = stop_trace ? wr_ptr + paddr[11:5] : wr_ptr;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn)
            wr_ptr <= '0;
        else if (sram_we)
            wr_ptr <= wr_ptr + TRACE_AW'(1);  // wraps at 128
    end

    for (genvar g = 0; g < REC_W / 64; g++) begin : g_sram
        trace_sram sram_inst (
            .clk  (clk),
            .we   (sram_we),
            .addr (sram_addr),
            .din  (rec[g*64 +: 64]),
            .dout (rd_rec[g*64 +: 64])
        );
    end

    assign trace_rdata = rd_rec[{paddr[4:2], 5'b0} +: 32];  // paddr held in access phase

    a_no_write_frozen: assert property (@(posedge clk) disable iff (!rstn)
        stop_trace |=> $stable(wr_ptr));

endmodule

// File: hw/dbgmon_top.sv
module dbgmon_top (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  logic [12:0]             paddr,
    input  logic [31:0]             pwdata,
    output logic [31:0]             prdata,
    output logic                    pready,
    output logic                    pslverr,
    input  logic [63:0]             pc,
    input  logic                    rec_valid,
    input  dbgmon_pkg::dbgmon_rec_u rec,
    output logic                    irq
);
    import dbgmon_pkg::*;

    logic [NUM_BP-1:0][62:0] bp_addr;
    logic [NUM_BP-1:0]       bp_en;
    logic [NUM_WP-1:0][62:0] wp_addr;
    logic [NUM_WP-1:0]       wp_en;
    logic [31:0]             vc_exc;
    logic [31:0]             vc_irq;
    logic [15:0]             delay;
    logic                    delay_wr;
    logic                    stop;
    logic                    stop_trace;
    logic                    ie;
    logic [31:0]             reg_rdata;
    logic [31:0]             trace_rdata;

    assign pready  = 1'b1;
    assign pslverr = 1'b0;
    assign prdata  = paddr[REG_BASE] ? reg_rdata : trace_rdata;
    assign irq     = stop_trace && ie;

    dbgmon_regs regs_inst (
        .clk        (clk),
        .rstn       (rstn),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .pc         (pc),
        .stop       (stop),
        .bp_addr    (bp_addr),
        .bp_en      (bp_en),
        .wp_addr    (wp_addr),
        .wp_en      (wp_en),
        .vc_exc     (vc_exc),
        .vc_irq     (vc_irq),
        .delay      (delay),
        .delay_wr   (delay_wr),
        .stop_trace (stop_trace),
        .ie         (ie),
        .reg_rdata  (reg_rdata)
    );

    dbgmon_trigger trigger_inst (
        .clk        (clk),
        .rstn       (rstn),
        .rec_valid  (rec_valid),
        .rec        (rec),
        .bp_addr    (bp_addr),
        .bp_en      (bp_en),
        .wp_addr    (wp_addr),
        .wp_en      (wp_en),
        .vc_exc     (vc_exc),
        .vc_irq     (vc_irq),
        .delay      (delay),
        .delay_wr   (delay_wr),
        .stop_trace (stop_trace),
        .stop       (stop)
    );

    dbgmon_trace trace_inst (
        .clk         (clk),
        .rstn        (rstn),
        .rec_valid   (rec_valid),
        .rec         (rec),
        .stop_trace  (stop_trace),
        .paddr       (paddr),
        .trace_rdata (trace_rdata)
    );

endmodule

// File: verification/tb_clkgen.sv
module tb_clkgen (
    output logic clk,
    output logic rstn
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int RESET_CYCLES = 16;

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;  // 100 ns period
    end

    initial begin
        rstn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rstn <= 1'b1;
    end

endmodule

// File: verification/tb_dbgmon.sv
module tb_dbgmon;
    timeunit 1ns;
    timeprecision 100ps;
    import dbgmon_pkg::*;

    localparam int MAX_CYCLES = 20000;  // ~1500 apb transfers of 4 cycles plus records

    logic        clk;
    logic        rstn;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [12:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic [63:0] pc;
    logic        rec_valid;
    dbgmon_rec_u rec;
    logic        irq;

    logic [31:0] lcg_state = 32'h5d19;
    int          cycles = 0;
    string       test_name;
    bit          frozen;    // expected stop_trace
    dbgmon_rec_u hist[$];   // stored records, oldest first

    tb_clkgen clkgen_inst (.clk(clk), .rstn(rstn));

    dbgmon_top dbgmon_top_inst (
        .clk       (clk),
        .rstn      (rstn),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .pc        (pc),
        .rec_valid (rec_valid),
        .rec       (rec),
        .irq       (irq)
    );

    task automatic fail_stop(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic compare_word(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp)
            fail_stop($sformatf("FAIL %s %s: expected %h, actual %h", test_name, what, exp, act));
    endtask

    task automatic compare_rec(input string what, input dbgmon_rec_u exp, input dbgmon_rec_u act);
        if (act !== exp)
            fail_stop($sformatf("FAIL %s %s: expected %h, actual %h", test_name, what, exp, act));
    endtask

    task automatic compare_bit(input string what, input logic exp, input logic act);
        if (act !== exp)
            fail_stop($sformatf("FAIL %s %s: expected %b, actual %b", test_name, what, exp, act));
    endtask

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // random record, never a trap
    function automatic dbgmon_rec_u make_rec();
        dbgmon_rec_u r;
        for (int w = 0; w < 8; w++)
            r[w*32 +: 32] = lcg_next();
        r.exec.kind = rec_kind_t'(2'(lcg_next() % 32'd3));
        return r;
    endfunction

    task automatic apb_write(input logic [12:0] addr, input logic [31:0] data);
        @(posedge clk);
        psel    <= 1'b1;
        pwrite  <= 1'b1;
        penable <= 1'b0;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic apb_read(input logic [12:0] addr, output logic [31:0] data);
        @(posedge clk);
        psel    <= 1'b1;
        pwrite  <= 1'b0;
        penable <= 1'b0;
        paddr   <= addr;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        data = prdata;  // access phase
        compare_bit("pready", 1'b1, pready);
        compare_bit("pslverr", 1'b0, pslverr);
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    // one record, then an idle cycle
    task automatic send_rec(input dbgmon_rec_u r);
        @(posedge clk);
        rec       <= r;
        rec_valid <= 1'b1;
        @(posedge clk);
        rec_valid <= 1'b0;
        if (!frozen) begin
            hist.push_back(r);
            if (hist.size() > TRACE_DEPTH)
                void'(hist.pop_front());
        end
    endtask

    task automatic verify_reg(input string what, input logic [12:0] addr, input logic [31:0] exp);
        logic [31:0] data;
        apb_read(addr, data);
        compare_word(what, exp, data);
    endtask

    task automatic sample_irq(input logic exp);
        @(negedge clk);
        compare_bit("irq", exp, irq);
    endtask

    task automatic read_back_entries(input int first);
        dbgmon_rec_u act;
        logic [31:0] word;
        for (int i = first; i < TRACE_DEPTH; i++) begin
            for (int w = 0; w < 8; w++) begin
                apb_read({1'b0, 7'(i), 3'(w), 2'b00}, word);
                act[w*32 +: 32] = word;
            end
            compare_rec($sformatf("entry %0d", i), hist[i], act);
        end
    endtask

    task automatic resume();
        apb_write(REG_STOP_TRACE, 32'd0);
        frozen = 1'b0;
    endtask

    task automatic clear_config();
        for (int i = 0; i < 4; i++) begin
            apb_write(REG_BP[i] + 13'h4, 32'd0);
            apb_write(REG_WP[i] + 13'h4, 32'd0);
        end
        apb_write(REG_VC_EXC, 32'd0);
        apb_write(REG_VC_IRQ, 32'd0);
        apb_write(REG_DELAY, 32'd0);
    endtask

    task automatic reset_and_rw();
        logic [12:0] addrs[20];
        logic [31:0] vals[20];
        logic [31:0] exp;
        logic [63:0] pc_val;
        test_name = "reset_and_rw";
        for (int i = 0; i < 4; i++) begin
            addrs[2*i]     = REG_BP[i];
            addrs[2*i+1]   = REG_BP[i] + 13'h4;  // enable in bit 31
            addrs[8+2*i]   = REG_WP[i];
            addrs[8+2*i+1] = REG_WP[i] + 13'h4;
        end
        addrs[16] = REG_VC_EXC;
        addrs[17] = REG_VC_IRQ;
        addrs[18] = REG_DELAY;
        addrs[19] = REG_IE;
        sample_irq(1'b0);
        verify_reg("reset stop_trace", REG_STOP_TRACE, 32'd0);
        for (int i = 0; i < 20; i++)
            verify_reg($sformatf("reset %h", addrs[i]), addrs[i], 32'd0);
        for (int i = 0; i < 20; i++) begin
            vals[i] = lcg_next();
            apb_write(addrs[i], vals[i]);
        end
        for (int i = 0; i < 20; i++) begin
            exp = vals[i];
            if (addrs[i] == REG_DELAY)
                exp = exp & 32'h0000_ffff;
            else if (addrs[i] == REG_IE)
                exp = exp & 32'h0000_0001;
            verify_reg($sformatf("readback %h", addrs[i]), addrs[i], exp);
        end
        pc_val = {lcg_next(), lcg_next()};
        @(posedge clk);
        pc <= pc_val;
        verify_reg("pc low", REG_PC, pc_val[31:0]);
        verify_reg("pc high", REG_PC + 13'h4, pc_val[63:32]);
        clear_config();
        apb_write(REG_IE, 32'd0);
    endtask

    task automatic freeze_readout();
        test_name = "freeze_readout";
        repeat (150) send_rec(make_rec());
        apb_write(REG_STOP_TRACE, 32'd1);
        frozen = 1'b1;
        verify_reg("stop_trace", REG_STOP_TRACE, 32'd1);
        repeat (5) send_rec(make_rec());
        read_back_entries(0);
    endtask

    task automatic breakpoint_stop();
        logic [62:0] bp;
        dbgmon_rec_u r;
        test_name = "breakpoint_stop";
        resume();
        bp = 63'({lcg_next(), lcg_next()});
        apb_write(REG_BP[2], bp[31:0]);
        apb_write(REG_BP[2] + 13'h4, {1'b0, bp[62:32]});
        apb_write(REG_IE, 32'd1);
        r = make_rec();
        r.exec.kind = KIND_EXEC;
        r.exec.pc   = bp;
        send_rec(r);
        verify_reg("disabled bp", REG_STOP_TRACE, 32'd0);
        apb_write(REG_BP[2] + 13'h4, {1'b1, bp[62:32]});
        repeat (8) send_rec(make_rec());
        r = make_rec();
        r.exec.kind = KIND_LOAD;
        r.exec.pc   = bp;
        send_rec(r);
        frozen = 1'b1;  // hit record is the last one stored
        sample_irq(1'b1);
        verify_reg("bp stop", REG_STOP_TRACE, 32'd1);
        repeat (3) send_rec(make_rec());
        read_back_entries(112);
    endtask

    task automatic watchpoint_delay();
        logic [62:0] wp;
        dbgmon_rec_u r;
        test_name = "watchpoint_delay";
        resume();
        clear_config();
        wp = 63'({lcg_next(), lcg_next()});
        apb_write(REG_WP[1], wp[31:0]);
        apb_write(REG_WP[1] + 13'h4, {1'b1, wp[62:32]});
        r = make_rec();
        r.exec.kind = KIND_EXEC;
        r.exec.addr = wp;
        send_rec(r);
        verify_reg("exec kind", REG_STOP_TRACE, 32'd0);  // delay 0 here, a hit would stop
        apb_write(REG_DELAY, 32'd4);
        r = make_rec();
        r.exec.kind = KIND_STORE;
        r.exec.addr = wp;
        send_rec(r);
        repeat (3) send_rec(make_rec());  // delay 4 keeps three more
        frozen = 1'b1;
        repeat (4) send_rec(make_rec());
        verify_reg("wp stop", REG_STOP_TRACE, 32'd1);
        read_back_entries(120);
    endtask

    task automatic vector_catch();
        dbgmon_rec_u r;
        test_name = "vector_catch";
        resume();
        clear_config();
        apb_write(REG_VC_IRQ, 32'h0000_0080);  // cause 7
        r = make_rec();
        r.trap.kind         = KIND_TRAP;
        r.trap.is_interrupt = 1'b0;
        r.trap.cause        = 5'd7;
        send_rec(r);
        verify_reg("exception cause", REG_STOP_TRACE, 32'd0);
        r.trap.is_interrupt = 1'b1;
        send_rec(r);
        frozen = 1'b1;
        verify_reg("interrupt cause", REG_STOP_TRACE, 32'd1);
        send_rec(make_rec());
        read_back_entries(124);
    endtask

    task automatic resume_and_retrigger();
        dbgmon_rec_u r;
        test_name = "resume_and_retrigger";
        resume();
        sample_irq(1'b0);
        repeat (10) send_rec(make_rec());
        verify_reg("running", REG_STOP_TRACE, 32'd0);
        r = make_rec();
        r.trap.kind         = KIND_TRAP;
        r.trap.is_interrupt = 1'b1;
        r.trap.cause        = 5'd7;
        send_rec(r);
        frozen = 1'b1;
        sample_irq(1'b1);
        read_back_entries(116);
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES)
            fail_stop($sformatf("timeout: %s did not finish within %0d cycles",
                                test_name, MAX_CYCLES));
    end

    initial begin
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        pc        = '0;
        rec_valid = 1'b0;
        rec       = '0;
        frozen    = 1'b0;
        test_name = "reset";
        wait (rstn === 1'b1);
        @(posedge clk);
        reset_and_rw();
        freeze_readout();
        breakpoint_stop();
        watchpoint_delay();
        vector_catch();
        resume_and_retrigger();
        $display("=== PASS ===");
        $finish;
    end

endmodule

// File: verilog.f
hw/dbgmon_pkg.sv
hw/trace_sram.sv
hw/dbgmon_regs.sv
hw/dbgmon_trigger.sv
hw/dbgmon_trace.sv
hw/dbgmon_top.sv
verification/tb_clkgen.sv
verification/tb_dbgmon.sv

// File: Makefile
VERILATOR  = verilator
VFLAGS     = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing
TOP        = tb_dbgmon
FILELIST   = verilog.f
OBJ_DIR    = obj_dir
PASS_MSG   = === PASS ===

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# status comes from grep, so a missing pass line fails the target
run: build
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -F "$(PASS_MSG)" > /dev/null

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
